//--- logic/dcache_pkg.sv
package dcache_pkg;

  // cache geometry
  localparam int s_offset   = 5;
  localparam int s_index    = 3;
  localparam int s_tag      = 24;
  localparam int num_sets   = 8;
  localparam int num_ways   = 4;
  localparam int line_bits  = 256;
  localparam int line_bytes = 32;

  // per-way, per-set metadata entry
  typedef struct packed {
    logic             valid;
    logic             dirty;
    logic [s_tag-1:0] tag;
  } meta_t;

  // pseudo-LRU tree state
  // bit 2 picks the half, bit 1 picks within ways 0/1, bit 0 within ways 2/3
  typedef logic [2:0] lru_t;

  // data write source for one way
  typedef enum logic [1:0] {
    no_write        = 2'b00,
    cpu_write_cache = 2'b01,
    mem_write_cache = 2'b10
  } way_write_t;

  // control FSM states
  typedef enum logic [1:0] {
    st_lookup    = 2'b00,
    st_writeback = 2'b01,
    st_fill      = 2'b10
  } ctrl_state_t;

endpackage

//--- logic/dcache_set_array.sv
`timescale 1ns/1ps

module dcache_set_array #(
  parameter type entry_t = logic,
  parameter entry_t reset_value = '0
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           load,
  input  logic [dcache_pkg::s_index-1:0] rindex,
  input  logic [dcache_pkg::s_index-1:0] windex,
  input  entry_t                         datain,
  output entry_t                         dataout
);

  entry_t entries [dcache_pkg::num_sets];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < dcache_pkg::num_sets; i++)
      begin
        entries[i] <= reset_value;
      end
    end
    else if (load)
    begin
      entries[windex] <= datain;
    end
  end

  // combinational read
  assign dataout = entries[rindex];

endmodule

//--- logic/dcache_way.sv
`timescale 1ns/1ps

module dcache_way (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [dcache_pkg::s_index-1:0]      index,
  input  logic [dcache_pkg::s_tag-1:0]        req_tag,
  input  logic [31:0]                         cpu_wdata,
  input  logic [3:0]                          cpu_strb,
  input  logic [dcache_pkg::s_offset-3:0]     word_sel,
  input  logic [dcache_pkg::line_bits-1:0]    fill_line,
  input  logic                                meta_load,
  input  dcache_pkg::way_write_t              data_write,
  output dcache_pkg::meta_t                   meta,
  output logic [dcache_pkg::line_bits-1:0]    line,
  output logic                                tag_match
);

  logic [dcache_pkg::line_bits-1:0]  data_mem [dcache_pkg::num_sets];
  logic [dcache_pkg::line_bytes-1:0] byte_en;
  logic [dcache_pkg::line_bits-1:0]  data_in;
  dcache_pkg::meta_t                 meta_in;

  always_comb
  begin
    byte_en = '0;
    data_in = '0;
    meta_in = meta;
    unique case (data_write)
      dcache_pkg::cpu_write_cache:
      begin
        // strobe lands on the four bytes of the selected word
        byte_en = {{(dcache_pkg::line_bytes-4){1'b0}}, cpu_strb} << {word_sel, 2'b00};
        data_in = {(dcache_pkg::line_bits/32){cpu_wdata}};
        meta_in.dirty = 1'b1;
      end
      dcache_pkg::mem_write_cache:
      begin
        byte_en = '1;
        data_in = fill_line;
        meta_in.valid = 1'b1;
        meta_in.dirty = 1'b0;
        meta_in.tag   = req_tag;
      end
      default:
      begin
        byte_en = '0;
      end
    endcase
  end

  dcache_set_array #(
    .entry_t(dcache_pkg::meta_t)
  ) u_meta (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (meta_load),
    .rindex  (index),
    .windex  (index),
    .datain  (meta_in),
    .dataout (meta)
  );

  // byte-writable line storage
  always_ff @(posedge clk)
  begin
    for (int b = 0; b < dcache_pkg::line_bytes; b++)
    begin
      if (byte_en[b])
      begin
        data_mem[index][8*b +: 8] <= data_in[8*b +: 8];
      end
    end
  end

  assign line      = data_mem[index];
  assign tag_match = meta.valid && (meta.tag == req_tag);

endmodule

//--- logic/dcache_metadata_check.sv
`timescale 1ns/1ps

module dcache_metadata_check (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [dcache_pkg::s_index-1:0]      index,
  input  logic [dcache_pkg::s_offset-3:0]     word_sel,
  input  logic [dcache_pkg::num_ways-1:0]     tag_match,
  input  dcache_pkg::meta_t                   metas [dcache_pkg::num_ways],
  input  logic [dcache_pkg::line_bits-1:0]    lines [dcache_pkg::num_ways],
  input  logic                                lru_update,
  output logic                                hit,
  output logic [1:0]                          hit_way,
  output logic [31:0]                         rdata_word,
  output logic [1:0]                          victim_way,
  output logic                                victim_dirty,
  output logic [31:0]                         wb_addr,
  output logic [dcache_pkg::line_bits-1:0]    wb_line
);

  dcache_pkg::lru_t lru;
  dcache_pkg::lru_t lru_next;
  logic [1:0]       tree_way;

  dcache_set_array #(
    .entry_t(dcache_pkg::lru_t)
  ) u_lru (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (lru_update),
    .rindex  (index),
    .windex  (index),
    .datain  (lru_next),
    .dataout (lru)
  );

  always_comb
  begin
    hit     = |tag_match;
    hit_way = '0;
    for (int w = dcache_pkg::num_ways-1; w >= 0; w--)
    begin
      if (tag_match[w])
      begin
        hit_way = 2'(w);
      end
    end
  end

  assign rdata_word = lines[hit_way][{word_sel, 5'b00000} +: 32];

  // the lowest invalid way wins over the tree victim
  always_comb
  begin
    tree_way   = lru[2] ? (lru[1] ? 2'd0 : 2'd1) : (lru[0] ? 2'd2 : 2'd3);
    victim_way = tree_way;
    for (int w = dcache_pkg::num_ways-1; w >= 0; w--)
    begin
      if (!metas[w].valid)
      begin
        victim_way = 2'(w);
      end
    end
  end

  assign victim_dirty = metas[victim_way].valid && metas[victim_way].dirty;
  assign wb_addr      = {metas[victim_way].tag, index, {dcache_pkg::s_offset{1'b0}}};
  assign wb_line      = lines[victim_way];

  // point the tree away from the way just used
  always_comb
  begin
    lru_next = lru;
    unique case (hit_way)
      2'd0:
      begin
        lru_next[2] = 1'b0;
        lru_next[1] = 1'b0;
      end
      2'd1:
      begin
        lru_next[2] = 1'b0;
        lru_next[1] = 1'b1;
      end
      2'd2:
      begin
        lru_next[2] = 1'b1;
        lru_next[0] = 1'b0;
      end
      default:
      begin
        lru_next[2] = 1'b1;
        lru_next[0] = 1'b1;
      end
    endcase
  end

endmodule

//--- logic/dcache_control.sv
`timescale 1ns/1ps

module dcache_control (
  input  logic                                clk,
  input  logic                                rst_n,
  // APB slave
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [31:0]                         paddr,
  input  logic [31:0]                         pwdata,
  input  logic [3:0]                          pstrb,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  // backing memory
  output logic                                mem_req,
  output logic                                mem_we,
  output logic [31:0]                         mem_addr,
  output logic [dcache_pkg::line_bits-1:0]    mem_wdata,
  input  logic [dcache_pkg::line_bits-1:0]    mem_rdata,
  input  logic                                mem_ack,
  // from metadata check
  input  logic                                hit,
  input  logic [1:0]                          hit_way,
  input  logic [1:0]                          victim_way,
  input  logic                                victim_dirty,
  input  logic [31:0]                         wb_addr,
  input  logic [dcache_pkg::line_bits-1:0]    wb_line,
  input  logic [31:0]                         rdata_word,
  // to the ways
  output logic [dcache_pkg::s_index-1:0]      index,
  output logic [dcache_pkg::s_tag-1:0]        req_tag,
  output logic [dcache_pkg::s_offset-3:0]     word_sel,
  output logic [31:0]                         cpu_wdata,
  output logic [3:0]                          cpu_strb,
  output logic [dcache_pkg::line_bits-1:0]    fill_line,
  output logic [dcache_pkg::num_ways-1:0]     meta_load,
  output dcache_pkg::way_write_t              data_write [dcache_pkg::num_ways],
  output logic                                lru_update
);

  dcache_pkg::ctrl_state_t state;
  logic [1:0]              victim_q;
  logic                    unaligned;
  logic                    lookup_access;
  logic                    hit_access;
  logic                    miss;
  logic                    fill_done;

  // address decode
  assign req_tag   = paddr[31:32-dcache_pkg::s_tag];
  assign index     = paddr[dcache_pkg::s_offset+dcache_pkg::s_index-1:dcache_pkg::s_offset];
  assign word_sel  = paddr[dcache_pkg::s_offset-1:2];
  assign cpu_wdata = pwdata;
  assign cpu_strb  = pstrb;
  assign fill_line = mem_rdata;

  assign unaligned     = |paddr[1:0];
  assign lookup_access = (state == dcache_pkg::st_lookup) && psel && penable;
  assign hit_access    = lookup_access && !unaligned && hit;
  assign miss          = lookup_access && !unaligned && !hit;
  assign fill_done     = (state == dcache_pkg::st_fill) && mem_req && mem_ack;

  // zero wait states on a hit or an error
  assign pready     = lookup_access && (unaligned || hit);
  assign pslverr    = lookup_access && unaligned;
  assign prdata     = (hit_access && !pwrite) ? rdata_word : '0;
  assign lru_update = hit_access;

  assign mem_we    = (state == dcache_pkg::st_writeback);
  assign mem_addr  = mem_we ? wb_addr : {paddr[31:dcache_pkg::s_offset], {dcache_pkg::s_offset{1'b0}}};
  assign mem_wdata = wb_line;

  always_comb
  begin
    meta_load = '0;
    for (int w = 0; w < dcache_pkg::num_ways; w++)
    begin
      data_write[w] = dcache_pkg::no_write;
    end
    if (hit_access && pwrite)
    begin
      meta_load[hit_way]  = 1'b1;
      data_write[hit_way] = dcache_pkg::cpu_write_cache;
    end
    else if (fill_done)
    begin
      meta_load[victim_q]  = 1'b1;
      data_write[victim_q] = dcache_pkg::mem_write_cache;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= dcache_pkg::st_lookup;
      mem_req  <= 1'b0;
      victim_q <= '0;
    end
    else
    begin
      unique case (state)
        dcache_pkg::st_lookup:
        begin
          if (miss)
          begin
            victim_q <= victim_way;
            mem_req  <= 1'b1;
            state    <= victim_dirty ? dcache_pkg::st_writeback : dcache_pkg::st_fill;
          end
        end
        dcache_pkg::st_writeback:
        begin
          // req drops for one cycle before the fill request
          if (mem_req && mem_ack)
          begin
            mem_req <= 1'b0;
            state   <= dcache_pkg::st_fill;
          end
        end
        dcache_pkg::st_fill:
        begin
          if (fill_done)
          begin
            mem_req <= 1'b0;
            state   <= dcache_pkg::st_lookup;
          end
          else
          begin
            mem_req <= 1'b1;
          end
        end
        default:
        begin
          state <= dcache_pkg::st_lookup;
        end
      endcase
    end
  end

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [31:0]                         paddr,
  input  logic [31:0]                         pwdata,
  input  logic [3:0]                          pstrb,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  output logic                                mem_req,
  output logic                                mem_we,
  output logic [31:0]                         mem_addr,
  output logic [dcache_pkg::line_bits-1:0]    mem_wdata,
  input  logic [dcache_pkg::line_bits-1:0]    mem_rdata,
  input  logic                                mem_ack
);

  logic [dcache_pkg::s_index-1:0]   index;
  logic [dcache_pkg::s_tag-1:0]     req_tag;
  logic [dcache_pkg::s_offset-3:0]  word_sel;
  logic [31:0]                      cpu_wdata;
  logic [3:0]                       cpu_strb;
  logic [dcache_pkg::line_bits-1:0] fill_line;
  logic [dcache_pkg::num_ways-1:0]  meta_load;
  dcache_pkg::way_write_t           data_write [dcache_pkg::num_ways];
  dcache_pkg::meta_t                metas [dcache_pkg::num_ways];
  logic [dcache_pkg::line_bits-1:0] lines [dcache_pkg::num_ways];
  logic [dcache_pkg::num_ways-1:0]  tag_match;
  logic                             hit;
  logic [1:0]                       hit_way;
  logic [1:0]                       victim_way;
  logic                             victim_dirty;
  logic [31:0]                      wb_addr;
  logic [dcache_pkg::line_bits-1:0] wb_line;
  logic [31:0]                      rdata_word;
  logic                             lru_update;

  dcache_control u_control (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .pstrb        (pstrb),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .mem_req      (mem_req),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .mem_ack      (mem_ack),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .wb_addr      (wb_addr),
    .wb_line      (wb_line),
    .rdata_word   (rdata_word),
    .index        (index),
    .req_tag      (req_tag),
    .word_sel     (word_sel),
    .cpu_wdata    (cpu_wdata),
    .cpu_strb     (cpu_strb),
    .fill_line    (fill_line),
    .meta_load    (meta_load),
    .data_write   (data_write),
    .lru_update   (lru_update)
  );

  for (genvar w = 0; w < dcache_pkg::num_ways; w++)
  begin : g_way
    dcache_way u_way (
      .clk        (clk),
      .rst_n      (rst_n),
      .index      (index),
      .req_tag    (req_tag),
      .cpu_wdata  (cpu_wdata),
      .cpu_strb   (cpu_strb),
      .word_sel   (word_sel),
      .fill_line  (fill_line),
      .meta_load  (meta_load[w]),
      .data_write (data_write[w]),
      .meta       (metas[w]),
      .line       (lines[w]),
      .tag_match  (tag_match[w])
    );
  end

  dcache_metadata_check u_check (
    .clk          (clk),
    .rst_n        (rst_n),
    .index        (index),
    .word_sel     (word_sel),
    .tag_match    (tag_match),
    .metas        (metas),
    .lines        (lines),
    .lru_update   (lru_update),
    .hit          (hit),
    .hit_way      (hit_way),
    .rdata_word   (rdata_word),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .wb_addr      (wb_addr),
    .wb_line      (wb_line)
  );

endmodule

//--- verification/dcache_clock_gen.sv
`timescale 1ns/1ps

module dcache_clock_gen #(
  parameter real period_ns = 4.0
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(period_ns / 2.0) clk = ~clk;
    end
  end

endmodule

//--- verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

  localparam int          max_cases    = 32;
  localparam int          case_fields  = 6;
  localparam int          random_ops   = 200;
  localparam int          op_budget    = 40;
  localparam int          reset_cycles = 8;
  localparam logic [31:0] pattern_key  = 32'hA5A50000;

  logic         clk;
  logic         rst_n;
  logic         psel;
  logic         penable;
  logic         pwrite;
  logic [31:0]  paddr;
  logic [31:0]  pwdata;
  logic [3:0]   pstrb;
  logic [31:0]  prdata;
  logic         pready;
  logic         pslverr;
  logic         mem_req;
  logic         mem_we;
  logic [31:0]  mem_addr;
  logic [255:0] mem_wdata;
  logic [255:0] mem_rdata;
  logic         mem_ack;

  // backing memory lines keyed by line address
  logic [255:0] mem_store [logic [26:0]];
  int           wb_count;
  logic [31:0]  last_wb_addr;
  int           req_wait;

  // expected contents of words written in the random phase
  logic [31:0]  shadow [logic [31:0]];
  logic [31:0]  case_words [max_cases*case_fields];
  int           n_cases;
  int           value_errors;
  int           other_errors;
  int           cycles;
  int           cycle_limit;
  logic [31:0]  lcg_state;

  dcache_clock_gen #(
    .period_ns(4.0)
  ) u_clk (
    .clk(clk)
  );

  dcache_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pstrb     (pstrb),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_ack   (mem_ack)
  );

  function automatic logic [31:0] pattern_word(input logic [31:0] addr);
    return addr ^ pattern_key;
  endfunction

  function automatic logic [255:0] pattern_line(input logic [26:0] line_addr);
    logic [255:0] l;
    for (int w = 0; w < 8; w++)
    begin
      l[32*w +: 32] = pattern_word({line_addr, 5'b00000} + 32'(4*w));
    end
    return l;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  strb);
    logic [31:0] r;
    r = old_word;
    for (int b = 0; b < 4; b++)
    begin
      if (strb[b])
      begin
        r[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return r;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    if (shadow.exists(addr))
    begin
      return shadow[addr];
    end
    return pattern_word(addr);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      value_errors++;
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
  endtask

  // one APB transfer with a setup phase and an access phase held until pready
  task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata,
                            output logic err);
    logic done;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    pstrb   = strb;
    @(posedge clk);
    #1;
    penable = 1'b1;
    done    = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      if (pready)
      begin
        rdata = prdata;
        err   = pslverr;
        done  = 1'b1;
      end
    end
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic run_case(input int i);
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] strb;
    logic [31:0] exp_rdata;
    logic [31:0] exp_err;
    logic [31:0] rdata;
    logic        err;
    op        = case_words[case_fields*i];
    addr      = case_words[case_fields*i+1];
    wdata     = case_words[case_fields*i+2];
    strb      = case_words[case_fields*i+3];
    exp_rdata = case_words[case_fields*i+4];
    exp_err   = case_words[case_fields*i+5];
    if (op == 32'd2)
    begin
      // writeback bookkeeping of the memory model
      check_value("writeback count", 32'(wb_count), wdata);
      if (wb_count != 0)
      begin
        check_value("writeback mem_addr", last_wb_addr, addr);
      end
    end
    else
    begin
      apb_access(op[0], addr, wdata, strb[3:0], rdata, err);
      check_value($sformatf("pslverr at %h", addr), {31'b0, err}, exp_err);
      if (op == 32'd0 && exp_err == 32'd0)
      begin
        check_value($sformatf("prdata at %h", addr), rdata, exp_rdata);
      end
    end
  endtask

  // 16 tags over all sets and words above the directed addresses
  task automatic run_random(input int count);
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic [31:0] rdata;
    logic [3:0]  strb;
    logic        err;
    for (int n = 0; n < count; n++)
    begin
      lcg_state = lcg_next(lcg_state);
      r         = lcg_state;
      addr      = {20'h00800, r[27:24], r[22:20], r[18:16], 2'b00};
      strb      = r[11:8];
      if (r[31])
      begin
        lcg_state = lcg_next(lcg_state);
        wdata     = lcg_state;
        apb_access(1'b1, addr, wdata, strb, rdata, err);
        shadow[addr] = merge_bytes(expected_word(addr), wdata, strb);
      end
      else
      begin
        exp = expected_word(addr);
        apb_access(1'b0, addr, 32'h0, 4'h0, rdata, err);
        check_value($sformatf("prdata at %h", addr), rdata, exp);
      end
      check_value($sformatf("pslverr at %h", addr), {31'b0, err}, 32'h0);
    end
  endtask

  // memory model acks three cycles after a request is seen
  initial
  begin
    mem_ack      = 1'b0;
    mem_rdata    = '0;
    req_wait     = 0;
    wb_count     = 0;
    last_wb_addr = '0;
    forever
    begin
      @(posedge clk);
      #1;
      if (mem_ack)
      begin
        mem_ack  = 1'b0;
        req_wait = 0;
      end
      else if (mem_req)
      begin
        req_wait++;
        if (req_wait == 3)
        begin
          assert (mem_addr[4:0] == 5'b00000)
          else
          begin
            other_errors++;
            $display("memory request address %h is not line-aligned", mem_addr);
          end
          if (mem_we)
          begin
            mem_store[mem_addr[31:5]] = mem_wdata;
            wb_count++;
            last_wb_addr = mem_addr;
          end
          else if (mem_store.exists(mem_addr[31:5]))
          begin
            mem_rdata = mem_store[mem_addr[31:5]];
          end
          else
          begin
            mem_rdata = pattern_line(mem_addr[31:5]);
          end
          mem_ack = 1'b1;
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      report_counts();
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial
  begin
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    pstrb        = '0;
    value_errors = 0;
    other_errors = 0;
    cycles       = 0;
    n_cases      = 0;
    lcg_state    = 32'h6c6242ce;
    for (int i = 0; i < max_cases*case_fields; i++)
    begin
      case_words[i] = '1;
    end
    $readmemh("verification/dcache_cases.txt", case_words);
    while (n_cases < max_cases && case_words[case_fields*n_cases] !== 32'hFFFFFFFF)
    begin
      n_cases++;
    end
    cycle_limit = reset_cycles + op_budget * (n_cases + random_ops);
    if (n_cases == 0)
    begin
      other_errors++;
      $display("no cases were read from verification/dcache_cases.txt");
    end

    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("pready", {31'b0, pready}, 32'h0);
    check_value("pslverr", {31'b0, pslverr}, 32'h0);
    check_value("mem_req", {31'b0, mem_req}, 32'h0);

    for (int i = 0; i < n_cases; i++)
    begin
      run_case(i);
    end
    run_random(random_ops);

    repeat (2) @(posedge clk);
    report_counts();
    if (value_errors + other_errors == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
logic/dcache_pkg.sv
logic/dcache_set_array.sv
logic/dcache_way.sv
logic/dcache_metadata_check.sv
logic/dcache_control.sv
logic/dcache_top.sv
verification/dcache_clock_gen.sv
verification/dcache_tb.sv

//--- verification/dcache_cases.txt
// op address wdata strobe expected_prdata expected_pslverr
// op 0 read, 1 write, 2 check writeback count (wdata) and last writeback address
0 00001004 00000000 0 A5A51004 0
1 00002048 11223344 5 00000000 0
0 00002048 00000000 0 A5222044 0
0 0000204C 00000000 0 A5A5204C 0
0 00002044 00000000 0 A5A52044 0
// four tags fill set 5, the fifth evicts way 0
1 000100A0 C0DE0001 F 00000000 0
1 000200A0 C0DE0002 F 00000000 0
1 000300A0 C0DE0003 F 00000000 0
1 000400A0 C0DE0004 F 00000000 0
2 00000000 00000000 0 00000000 0
1 000500A0 C0DE0005 F 00000000 0
2 000100A0 00000001 0 00000000 0
// refill of the evicted line pushes out way 2
0 000100A0 00000000 0 C0DE0001 0
0 000100A4 00000000 0 A5A400A4 0
2 000300A0 00000002 0 00000000 0
0 000500A0 00000000 0 C0DE0005 0
0 000400A0 00000000 0 C0DE0004 0
// unaligned accesses leave the cache untouched
1 00002049 FFFFFFFF F 00000000 1
0 00003002 00000000 0 00000000 1
0 00002048 00000000 0 A5222044 0
2 000300A0 00000002 0 00000000 0
